// File: rtl/alu_exec.sv
`default_nettype none

module alu_exec (
    input  wire logic                 clk,
    input  wire logic                 rst_n,
    input  wire logic                 flush,
    input  wire logic                 req_valid,
    output logic                      req_ready,
    input  wire rv_alu_pkg::alu_op_e  op,
    input  wire rv_alu_pkg::xlen_t    pc,
    input  wire rv_alu_pkg::xlen_t    rs1,
    input  wire rv_alu_pkg::xlen_t    rs2,
    input  wire rv_alu_pkg::xlen_t    csr,
    input  wire rv_alu_pkg::xlen_t    imm,
    input  wire rv_alu_pkg::sel_a_e   sel_a,
    input  wire rv_alu_pkg::sel_b_e   sel_b,
    input  wire logic                 word,
    input  wire logic                 rob_full,
    output logic                      alloc,
    output exu_cfg_pkg::tag_t         alloc_tag,
    output logic                      alu_wr_valid,
    output exu_cfg_pkg::tag_t         alu_wr_tag,
    output rv_alu_pkg::xlen_t         alu_wr_data,
    output logic                      mreq_valid,
    input  wire logic                 mreq_ready,
    output rv_alu_pkg::xlen_t         mreq_a,
    output rv_alu_pkg::xlen_t         mreq_b,
    output exu_cfg_pkg::tag_t         mreq_tag
);
    import rv_alu_pkg::*;
    import exu_cfg_pkg::*;

    tag_t  next_tag;
    xlen_t opa;
    xlen_t opb;
    xlen_t result;
    logic  is_mul;
    logic  accept;

    // rs1 narrowed for word ops, pc is never narrowed
    assign opa = (sel_a == sel_a_rs1) ? (word ? {32'b0, rs1[31:0]} : rs1) : pc;

    always_comb begin
        case (sel_b)
            sel_b_rs2: opb = rs2;
            sel_b_csr: opb = csr;
            default:   opb = imm;
        endcase
    end

    assign is_mul = (op == op_mul);

    // a multiply also needs the dispatcher to have room
    assign req_ready = !flush && !rob_full && (!is_mul || mreq_ready);
    assign accept    = req_valid && req_ready;

    assign alloc     = accept;
    assign alloc_tag = next_tag;

    // multiply offer does not look at mreq_ready
    assign mreq_valid = req_valid && is_mul && !rob_full && !flush;
    assign mreq_a     = opa;
    assign mreq_b     = opb;
    assign mreq_tag   = next_tag;

    always_comb begin
        case (op)
            op_add:    result = opa + opb;
            op_sub:    result = opa - opb;
            op_pass_a: result = opa;
            op_pass_b: result = opb;
            op_xor:    result = opa ^ opb;
            op_or:     result = opa | opb;
            op_and:    result = opa & opb;
            op_sll:    result = opa << opb[5:0];
            op_srl:    result = opa >> opb[5:0];
            // word form shifts the low half and zero fills the top
            op_sra: begin
                if (word) begin
                    result = {32'b0, $signed(opa[31:0]) >>> opb[5:0]};
                end else begin
                    result = $signed(opa) >>> opb[5:0];
                end
            end
            op_slt:    result = {63'b0, $signed(opa) < $signed(opb)};
            op_sltu:   result = {63'b0, opa < opb};
            op_eq:     result = {63'b0, opa == opb};
            op_ge:     result = {63'b0, $signed(opa) >= $signed(opb)};
            op_geu:    result = {63'b0, opa >= opb};
            default:   result = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            next_tag     <= '0;
            alu_wr_valid <= 1'b0;
        end else if (flush) begin
            next_tag     <= '0;
            alu_wr_valid <= 1'b0;
        end else begin
            if (accept) begin
                next_tag <= next_tag + 1'b1;
            end
            alu_wr_valid <= accept && !is_mul;
        end
    end

    always_ff @(posedge clk) begin
        if (accept && !is_mul) begin
            alu_wr_tag  <= next_tag;
            alu_wr_data <= result;
        end
    end

    // tag reuse is blocked by rob_full from the collector
    a_tag_distinct: assert property (@(posedge clk) disable iff (!rst_n)
        !(mreq_valid && alu_wr_valid && (mreq_tag == alu_wr_tag)));

endmodule

`default_nettype wire

// File: rtl/exu_cfg_pkg.sv
`default_nettype none

package exu_cfg_pkg;

    localparam int NUM_LANES     = 4;
    localparam int TAG_W         = 3;
    // one entry per tag value
    localparam int ROB_DEPTH     = 1 << TAG_W;
    localparam int MUL_STEP_BITS = 2;
    localparam int MUL_CYCLES    = rv_alu_pkg::XLEN / MUL_STEP_BITS;
    localparam int MUL_CNT_W     = $clog2(MUL_CYCLES);
    localparam int LANE_W        = $clog2(NUM_LANES);

    // request order tag, also the reorder slot
    typedef logic [TAG_W-1:0] tag_t;

    typedef logic [LANE_W-1:0] lane_idx_t;

endpackage

`default_nettype wire

// File: rtl/exu_top.sv
`default_nettype none

module exu_top (
    input  wire logic                 clk,
    input  wire logic                 rst_n,
    input  wire logic                 flush,
    input  wire logic                 req_valid,
    output logic                      req_ready,
    input  wire rv_alu_pkg::alu_op_e  op,
    input  wire rv_alu_pkg::xlen_t    pc,
    input  wire rv_alu_pkg::xlen_t    rs1,
    input  wire rv_alu_pkg::xlen_t    rs2,
    input  wire rv_alu_pkg::xlen_t    csr,
    input  wire rv_alu_pkg::xlen_t    imm,
    input  wire rv_alu_pkg::sel_a_e   sel_a,
    input  wire rv_alu_pkg::sel_b_e   sel_b,
    input  wire logic                 word,
    output logic                      res_valid,
    input  wire logic                 res_ready,
    output rv_alu_pkg::xlen_t         res_data
);
    import rv_alu_pkg::*;
    import exu_cfg_pkg::*;

    logic                    rob_full;
    logic                    alloc;
    logic                    alu_wr_valid;
    tag_t                    alu_wr_tag;
    xlen_t                   alu_wr_data;
    logic                    mreq_valid;
    logic                    mreq_ready;
    xlen_t                   mreq_a;
    xlen_t                   mreq_b;
    tag_t                    mreq_tag;
    logic [NUM_LANES-1:0]    lane_busy;
    logic [NUM_LANES-1:0]    lane_start;
    xlen_t                   start_a;
    xlen_t                   start_b;
    tag_t                    start_tag;
    logic [NUM_LANES-1:0]    lane_done;
    tag_t [NUM_LANES-1:0]    lane_tag;
    xlen_t [NUM_LANES-1:0]   lane_data;

    // slot comes from the ALU tag counter, so the collector only needs the pulse
    alu_exec u_alu (
        .clk, .rst_n, .flush,
        .req_valid, .req_ready,
        .op, .pc, .rs1, .rs2, .csr, .imm, .sel_a, .sel_b, .word,
        .rob_full,
        .alloc, .alloc_tag (),
        .alu_wr_valid, .alu_wr_tag, .alu_wr_data,
        .mreq_valid, .mreq_ready, .mreq_a, .mreq_b, .mreq_tag
    );

    mul_dispatch u_disp (
        .clk, .rst_n, .flush,
        .mreq_valid, .mreq_ready, .mreq_a, .mreq_b, .mreq_tag,
        .lane_busy, .lane_start,
        .start_a, .start_b, .start_tag
    );

    // operands fan out to all lanes and start picks one
    for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
        mul_lane u_lane (
            .clk, .rst_n, .flush,
            .start     (lane_start[i]),
            .start_a   (start_a),
            .start_b   (start_b),
            .start_tag (start_tag),
            .busy      (lane_busy[i]),
            .done      (lane_done[i]),
            .done_tag  (lane_tag[i]),
            .done_data (lane_data[i])
        );
    end

    result_collect u_rob (
        .clk, .rst_n, .flush,
        .alloc, .rob_full,
        .alu_wr_valid, .alu_wr_tag, .alu_wr_data,
        .lane_done, .lane_tag, .lane_data,
        .res_valid, .res_ready, .res_data
    );

endmodule

`default_nettype wire

// File: rtl/mul_dispatch.sv
`default_nettype none

module mul_dispatch (
    input  wire logic                                clk,
    input  wire logic                                rst_n,
    input  wire logic                                flush,
    input  wire logic                                mreq_valid,
    output logic                                     mreq_ready,
    input  wire rv_alu_pkg::xlen_t                   mreq_a,
    input  wire rv_alu_pkg::xlen_t                   mreq_b,
    input  wire exu_cfg_pkg::tag_t                   mreq_tag,
    input  wire logic [exu_cfg_pkg::NUM_LANES-1:0]   lane_busy,
    output logic [exu_cfg_pkg::NUM_LANES-1:0]        lane_start,
    output rv_alu_pkg::xlen_t                        start_a,
    output rv_alu_pkg::xlen_t                        start_b,
    output exu_cfg_pkg::tag_t                        start_tag
);
    import rv_alu_pkg::*;
    import exu_cfg_pkg::*;

    logic      buf_valid;
    logic      found;
    logic      issue;
    lane_idx_t pick;

    // lowest numbered idle lane wins
    always_comb begin
        found = 1'b0;
        pick  = '0;
        for (int i = NUM_LANES - 1; i >= 0; i--) begin
            if (!lane_busy[i]) begin
                found = 1'b1;
                pick  = lane_idx_t'(i);
            end
        end
    end

    assign issue = buf_valid && found && !flush;

    always_comb begin
        lane_start = '0;
        if (issue) begin
            lane_start[pick] = 1'b1;
        end
    end

    // room if empty or draining this cycle
    assign mreq_ready = !buf_valid || found;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            buf_valid <= 1'b0;
        end else if (flush) begin
            buf_valid <= 1'b0;
        end else if (mreq_valid && mreq_ready) begin
            buf_valid <= 1'b1;
        end else if (issue) begin
            buf_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (mreq_valid && mreq_ready) begin
            start_a   <= mreq_a;
            start_b   <= mreq_b;
            start_tag <= mreq_tag;
        end
    end

    a_start_legal: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(lane_start) && ((lane_start & lane_busy) == '0));

endmodule

`default_nettype wire

// File: rtl/mul_lane.sv
`default_nettype none

module mul_lane (
    input  wire logic                clk,
    input  wire logic                rst_n,
    input  wire logic                flush,
    input  wire logic                start,
    input  wire rv_alu_pkg::xlen_t   start_a,
    input  wire rv_alu_pkg::xlen_t   start_b,
    input  wire exu_cfg_pkg::tag_t   start_tag,
    output logic                     busy,
    output logic                     done,
    output exu_cfg_pkg::tag_t        done_tag,
    output rv_alu_pkg::xlen_t        done_data
);
    import rv_alu_pkg::*;
    import exu_cfg_pkg::*;

    typedef enum logic {
        st_idle,
        st_run
    } lane_state_e;

    lane_state_e          state;
    logic [MUL_CNT_W-1:0] cnt;
    xlen_t                acc;
    xlen_t                mcand;
    xlen_t                mplier;
    xlen_t                acc_next;

    // one radix-4 digit per cycle, multiplicand pre-shifted
    assign acc_next = acc + mcand * xlen_t'(mplier[MUL_STEP_BITS-1:0]);
    assign busy     = (state == st_run);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= st_idle;
            cnt   <= '0;
            done  <= 1'b0;
        end else if (flush) begin
            state <= st_idle;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                st_idle: begin
                    if (start) begin
                        state <= st_run;
                        cnt   <= MUL_CNT_W'(MUL_CYCLES - 1);
                    end
                end
                st_run: begin
                    if (cnt == '0) begin
                        state <= st_idle;
                        done  <= 1'b1;
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_idle && start) begin
            acc      <= '0;
            mcand    <= start_a;
            mplier   <= start_b;
            done_tag <= start_tag;
        end else if (state == st_run) begin
            acc    <= acc_next;
            mcand  <= mcand << MUL_STEP_BITS;
            mplier <= mplier >> MUL_STEP_BITS;
            // last digit lands straight in the result
            if (cnt == '0) begin
                done_data <= acc_next;
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/result_collect.sv
`default_nettype none

module result_collect (
    input  wire logic                                                    clk,
    input  wire logic                                                    rst_n,
    input  wire logic                                                    flush,
    input  wire logic                                                    alloc,
    output logic                                                         rob_full,
    input  wire logic                                                    alu_wr_valid,
    input  wire exu_cfg_pkg::tag_t                                       alu_wr_tag,
    input  wire rv_alu_pkg::xlen_t                                       alu_wr_data,
    input  wire logic [exu_cfg_pkg::NUM_LANES-1:0]                       lane_done,
    input  wire exu_cfg_pkg::tag_t [exu_cfg_pkg::NUM_LANES-1:0]          lane_tag,
    input  wire rv_alu_pkg::xlen_t [exu_cfg_pkg::NUM_LANES-1:0]          lane_data,
    output logic                                                         res_valid,
    input  wire logic                                                    res_ready,
    output rv_alu_pkg::xlen_t                                            res_data
);
    import rv_alu_pkg::*;
    import exu_cfg_pkg::*;

    xlen_t                mem [ROB_DEPTH];
    logic [ROB_DEPTH-1:0] filled;
    logic [ROB_DEPTH-1:0] filled_next;
    tag_t                 head;
    // counts the output register entry too
    logic [TAG_W:0]       count;
    logic                 out_valid;
    logic                 deliver;
    logic                 load_out;
    logic                 wr_conflict;

    assign rob_full  = (count == (TAG_W + 1)'(ROB_DEPTH));
    assign res_valid = out_valid && !flush;
    assign deliver   = res_valid && res_ready;
    assign load_out  = filled[head] && (!out_valid || deliver);

    always_comb begin
        filled_next = filled;
        wr_conflict = alu_wr_valid && filled[alu_wr_tag];
        if (load_out) begin
            filled_next[head] = 1'b0;
        end
        if (alu_wr_valid) begin
            filled_next[alu_wr_tag] = 1'b1;
        end
        for (int i = 0; i < NUM_LANES; i++) begin
            if (lane_done[i]) begin
                wr_conflict = wr_conflict || filled[lane_tag[i]];
                filled_next[lane_tag[i]] = 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            filled    <= '0;
            head      <= '0;
            count     <= '0;
            out_valid <= 1'b0;
        end else if (flush) begin
            filled    <= '0;
            head      <= '0;
            count     <= '0;
            out_valid <= 1'b0;
        end else begin
            filled <= filled_next;
            count  <= count + (TAG_W + 1)'(alloc) - (TAG_W + 1)'(deliver);
            if (load_out) begin
                out_valid <= 1'b1;
                head      <= head + 1'b1;
            end else if (deliver) begin
                out_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (alu_wr_valid) begin
            mem[alu_wr_tag] <= alu_wr_data;
        end
        for (int i = 0; i < NUM_LANES; i++) begin
            if (lane_done[i]) begin
                mem[lane_tag[i]] <= lane_data[i];
            end
        end
        if (load_out) begin
            res_data <= mem[head];
        end
    end

    // every slot is allocated once, so a second write means a tag mixup upstream
    a_no_overwrite: assert property (@(posedge clk) disable iff (!rst_n || flush)
        !wr_conflict);

endmodule

`default_nettype wire

// File: rtl/rv_alu_pkg.sv
`default_nettype none

package rv_alu_pkg;

    localparam int XLEN = 64;

    // operand and result word
    typedef logic [XLEN-1:0] xlen_t;

    // single-cycle ops plus the iterative multiply
    typedef enum logic [4:0] {
        op_add    = 5'd0,
        op_sub    = 5'd1,
        op_pass_a = 5'd2,
        op_pass_b = 5'd3,
        op_xor    = 5'd4,
        op_or     = 5'd5,
        op_and    = 5'd6,
        op_sll    = 5'd7,
        op_srl    = 5'd8,
        op_sra    = 5'd9,
        op_slt    = 5'd10,
        op_sltu   = 5'd11,
        op_eq     = 5'd12,
        op_ge     = 5'd13,
        op_geu    = 5'd14,
        op_mul    = 5'd15
    } alu_op_e;

    // operand a source
    typedef enum logic {
        sel_a_pc  = 1'b0,
        sel_a_rs1 = 1'b1
    } sel_a_e;

    // operand b source, anything unlisted falls back to imm
    typedef enum logic [1:0] {
        sel_b_imm = 2'd0,
        sel_b_rs2 = 2'd1,
        sel_b_csr = 2'd2
    } sel_b_e;

endpackage

`default_nettype wire

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_exu -f sources.f -o sim_exu \
    || { echo "build failed"; exit 1; }
./obj_dir/sim_exu > sim.log 2>&1 || { cat sim.log; echo "simulation aborted"; exit 1; }
cat sim.log
grep -q "Test failed" sim.log && exit 1 || exit 0

// File: sources.f
rtl/rv_alu_pkg.sv
rtl/exu_cfg_pkg.sv
rtl/alu_exec.sv
rtl/mul_dispatch.sv
rtl/mul_lane.sv
rtl/result_collect.sv
rtl/exu_top.sv
test/tb_exu.sv

// File: test/tb_exu.sv
`default_nettype none

module tb_exu;
    import rv_alu_pkg::*;
    import exu_cfg_pkg::*;

    localparam int NUM_TESTS   = 6;
    localparam int REQS        = 40;
    localparam int WATCHDOG    = NUM_TESTS * REQS * (MUL_CYCLES + 10) * 4;
    localparam int DRAIN_LIMIT = REQS * (MUL_CYCLES + 10);

    logic    clk = 1'b0;
    logic    rst_n = 1'b0;
    logic    flush = 1'b0;
    logic    req_valid = 1'b0;
    logic    req_ready;
    alu_op_e op = op_add;
    xlen_t   pc = '0;
    xlen_t   rs1 = '0;
    xlen_t   rs2 = '0;
    xlen_t   csr = '0;
    xlen_t   imm = '0;
    sel_a_e  sel_a = sel_a_rs1;
    sel_b_e  sel_b = sel_b_rs2;
    logic    word = 1'b0;
    logic    res_valid;
    logic    res_ready = 1'b1;
    xlen_t   res_data;

    integer seed = 32'hddc17521;
    int     err_count = 0;
    int     test_err_base = 0;
    int     test_num = 0;
    int     fail_tests = 0;
    // 0 always ready, 1 random, 2 held low
    int     ready_mode = 0;
    logic   idle_check = 1'b0;
    xlen_t  cur_exp = '0;
    xlen_t  acc_exp = '0;
    logic   acc_fire = 1'b0;
    logic   res_fire = 1'b0;
    logic   flush_fire = 1'b0;
    xlen_t  exp_q[$];
    xlen_t  exp_head = '0;
    int     exp_count = 0;

    exu_top uut (.*);

    always #2 clk = ~clk;

    // handshakes seen at the rising edge, the queue moves at the falling edge
    always @(posedge clk) begin
        acc_fire   <= req_valid && req_ready;
        acc_exp    <= cur_exp;
        res_fire   <= res_valid && res_ready;
        flush_fire <= flush;
    end

    always @(negedge clk) begin
        if (res_fire)
            void'(exp_q.pop_front());
        if (acc_fire)
            exp_q.push_back(acc_exp);
        if (flush_fire)
            exp_q.delete();
        exp_count = exp_q.size();
        exp_head  = (exp_q.size() > 0) ? exp_q[0] : '0;
        case (ready_mode)
            1: res_ready = 1'($random(seed));
            2: res_ready = 1'b0;
            default: res_ready = 1'b1;
        endcase
    end

    function automatic xlen_t rand64();
        int k;
        k = int'($unsigned($random(seed)) % 8);
        case (k)
            0: return '0;
            1: return '1;
            // small values give useful shift amounts
            2: return xlen_t'($unsigned($random(seed)) % 70);
            default: return {$random(seed), $random(seed)};
        endcase
    endfunction

    function automatic alu_op_e pick_alu_op();
        return alu_op_e'(5'($unsigned($random(seed)) % 15));
    endfunction

    function automatic alu_op_e pick_mixed_op();
        if (($unsigned($random(seed)) % 4) == 0)
            return op_mul;
        return pick_alu_op();
    endfunction

    // expected result straight from the operation rules
    function automatic xlen_t model(alu_op_e f, xlen_t a, xlen_t b, logic w);
        xlen_t sa;
        xlen_t sb;
        xlen_t x;
        int    sh;
        sh = int'(b[5:0]);
        // bias the sign bit so an unsigned compare orders signed values
        sa = a ^ {1'b1, 63'b0};
        sb = b ^ {1'b1, 63'b0};
        case (f)
            op_add:    return a + b;
            op_sub:    return a - b;
            op_pass_a: return a;
            op_pass_b: return b;
            op_xor:    return a ^ b;
            op_or:     return a | b;
            op_and:    return a & b;
            op_sll:    return a << sh;
            op_srl:    return a >> sh;
            op_sra: begin
                x = w ? {{32{a[31]}}, a[31:0]} : a;
                x = (x >> sh) | (x[63] ? ~(~64'd0 >> sh) : 64'd0);
                return w ? {32'b0, x[31:0]} : x;
            end
            op_slt:    return xlen_t'(sa < sb);
            op_sltu:   return xlen_t'(a < b);
            op_eq:     return xlen_t'(a == b);
            op_ge:     return xlen_t'(sa >= sb);
            op_geu:    return xlen_t'(a >= b);
            op_mul:    return a * b;
            default:   return '0;
        endcase
    endfunction

    // called on a falling edge, returns on the falling edge after the transfer
    task automatic send(alu_op_e f, logic w);
        xlen_t a;
        xlen_t b;
        pc    = rand64();
        rs1   = rand64();
        rs2   = rand64();
        csr   = rand64();
        imm   = rand64();
        sel_a = sel_a_e'(1'($random(seed)));
        sel_b = sel_b_e'(2'($random(seed)));
        op    = f;
        word  = w;
        a = (sel_a == sel_a_rs1) ? (w ? {32'b0, rs1[31:0]} : rs1) : pc;
        case (sel_b)
            sel_b_rs2: b = rs2;
            sel_b_csr: b = csr;
            default:   b = imm;
        endcase
        cur_exp   = model(f, a, b, w);
        req_valid = 1'b1;
        @(negedge clk);
        while (!acc_fire) begin
            @(negedge clk);
        end
        req_valid = 1'b0;
    endtask

    task automatic end_test(string name);
        int n;
        n = 0;
        while (exp_count != 0 && n < DRAIN_LIMIT) begin
            @(negedge clk);
            n++;
        end
        // leave room for a stray extra result
        repeat (8) @(negedge clk);
        if (exp_count != 0) begin
            $display("%s: %0d results never came back", name, exp_count);
            err_count++;
        end
        test_num++;
        if (err_count != test_err_base)
            fail_tests++;
        $display("test %0d %s: %0d errors", test_num, name, err_count - test_err_base);
        test_err_base = err_count;
    endtask

    a_res_data: assert property (@(posedge clk) disable iff (!rst_n)
        (res_valid && res_ready) |-> (res_data == exp_head))
        else begin
            $display("FAILED time %0t res_data got %h expected %h",
                     $time, $sampled(res_data), exp_head);
            err_count++;
        end

    a_no_extra: assert property (@(posedge clk) disable iff (!rst_n)
        res_valid |-> (exp_count != 0))
        else begin
            $display("time %0t: result offered with no request outstanding", $time);
            err_count++;
        end

    a_res_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (res_valid && !res_ready && !flush) |=> (flush || (res_valid && $stable(res_data))))
        else begin
            $display("time %0t: result dropped or changed while stalled", $time);
            err_count++;
        end

    a_full_stall: assert property (@(posedge clk) disable iff (!rst_n)
        (exp_count == ROB_DEPTH) |-> !req_ready)
        else begin
            $display("time %0t: req_ready high with the reorder buffer full", $time);
            err_count++;
        end

    a_flush_quiet: assert property (@(posedge clk) disable iff (!rst_n)
        flush |-> (!req_ready && !res_valid))
        else begin
            $display("time %0t: handshake open during flush", $time);
            err_count++;
        end

    a_reset_idle: assert property (@(posedge clk) disable iff (!rst_n)
        idle_check |-> (req_ready && !res_valid))
        else begin
            $display("time %0t: not idle after reset", $time);
            err_count++;
        end

    initial begin
        #(WATCHDOG);
        $display("watchdog expired before the tests finished");
        $display("Test failed");
        $finish;
    end

    initial begin
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n      = 1'b1;
        idle_check = 1'b1;
        repeat (4) @(negedge clk);
        idle_check = 1'b0;
        end_test("reset state");

        for (int i = 0; i < REQS; i++)
            send(pick_alu_op(), 1'($random(seed)));
        end_test("single-cycle ops");

        for (int i = 0; i < REQS; i++)
            send(op_mul, 1'($random(seed)));
        end_test("multiplies");

        for (int i = 0; i < REQS; i++)
            send(pick_mixed_op(), 1'($random(seed)));
        end_test("mixed order");

        // fill the reorder buffer, then drain at random
        ready_mode = 2;
        repeat (ROB_DEPTH) send(pick_alu_op(), 1'($random(seed)));
        repeat (4) @(negedge clk);
        ready_mode = 1;
        for (int i = ROB_DEPTH; i < REQS; i++)
            send(pick_mixed_op(), 1'($random(seed)));
        end_test("back-pressure");

        ready_mode = 2;
        repeat (6) send(pick_mixed_op(), 1'($random(seed)));
        flush = 1'b1;
        @(negedge clk);
        flush      = 1'b0;
        ready_mode = 0;
        for (int i = 0; i < REQS; i++)
            send(pick_mixed_op(), 1'($random(seed)));
        end_test("flush");

        $display("tests run %0d, tests with errors %0d, check errors %0d",
                 test_num, fail_tests, err_count);
        if (fail_tests == 0 && err_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
